// File: feistel48_top.f
+incdir+tb
src/feistel48_pkg.sv
src/feistel_round_function.sv
src/feistel_key_schedule.sv
src/feistel_ctrl.sv
src/feistel_datapath.sv
src/feistel48_top.sv
tb/feistel48_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module feistel48_tb -f feistel48_top.f -o feistel48_sim

output=$(./obj_dir/feistel48_sim)
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb/feistel48_model.svh
// Feistel-48 reference model
// Round key derivation, F-function and whole-block encrypt/decrypt
// written straight from the cipher rules, plus a 32-bit Fibonacci LFSR
`ifndef FEISTEL48_MODEL_SVH
`define FEISTEL48_MODEL_SVH

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

function automatic half_t rotr64(input half_t x, input int n);
    return (x >> n) | (x << (HALF_W - n));
endfunction

function automatic half_t rotl64(input half_t x, input int n);
    return (x << n) | (x >> (HALF_W - n));
endfunction

function automatic half_t model_f(input half_t x, input round_key_t k);
    half_t t;
    half_t s;
    half_t d;
    half_t a;
    t = x ^ k[HALF_W-1:0];
    for (int b = 0; b < HALF_W / 8; b++) begin
        s[b*8 +: 8] = SBOX[t[b*8 +: 8]];
    end
    d = s ^ rotr64(s, 7) ^ rotr64(s, 11);
    a = (d + PHI_64) ^ rotl64(d, 13) ^ rotr64(d, 29);
    return a ^ k[ROUND_KEY_W-1:HALF_W];
endfunction

function automatic round_key_t model_round_key(input master_key_t key, input int r);
    master_key_t prk;
    master_key_t v;
    master_key_t mixed;
    prk   = key ^ HKDF_SALT;
    v     = prk ^ (PHI_256 * master_key_t'(r));
    mixed = ((v << 32) | (v >> (KEY_W - 32))) + v;
    return mixed[ROUND_KEY_W-1:0] ^ mixed[KEY_W-1:ROUND_KEY_W];
endfunction

function automatic block_t model_cipher(input cipher_req_t req);
    master_key_t prk;
    round_key_t  pre_key;
    round_key_t  post_key;
    round_key_t  first_key;
    round_key_t  last_key;
    block_t      b;
    half_t       l;
    half_t       r;
    half_t       tmp;
    int          idx;
    prk      = req.key ^ HKDF_SALT;
    pre_key  = prk[ROUND_KEY_W-1:0] ^ PRE_WHITEN_CONST[ROUND_KEY_W-1:0];
    post_key = prk[KEY_W-1:ROUND_KEY_W] ^ POST_WHITEN_CONST[KEY_W-1:ROUND_KEY_W];
    // Decryption swaps the whitening keys
    first_key = (req.dir == CIPHER_ENCRYPT) ? pre_key : post_key;
    last_key  = (req.dir == CIPHER_ENCRYPT) ? post_key : pre_key;
    b = req.block ^ first_key;
    l = b[BLOCK_W-1:HALF_W];
    r = b[HALF_W-1:0];
    for (int i = 0; i < ROUNDS; i++) begin
        idx = (req.dir == CIPHER_ENCRYPT) ? i : ROUNDS - 1 - i;
        tmp = l ^ model_f(r, model_round_key(req.key, idx));
        l   = r;
        r   = tmp;
    end
    return {r, l} ^ last_key;
endfunction

`endif

// File: tb/feistel48_tb.sv
// Feistel-48 testbench
// Directed tests of reset state, fixed encryption and decryption, an
// ignored start during an operation and back-to-back random round trips
module feistel48_tb
    import feistel48_pkg::*;
();

    `include "feistel48_model.svh"

    localparam int          DRIVE_DLY    = 2;
    localparam int          RESET_CYCLES = 16;
    localparam int          OP_CYCLES    = 99;
    localparam logic [31:0] LFSR_SEED    = 32'h5c90_17d9;
    // 26 operations of about 100 cycles, the watch window and margin
    localparam int          NUM_OPS        = 26;
    localparam int          TIMEOUT_CYCLES = (NUM_OPS + 14) * 100;

    logic        clk;
    logic        reset;
    logic        start_i;
    cipher_req_t req_i;
    logic        busy_o;
    logic        done_o;
    block_t      block_o;

    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          test_errs;
    int          timeout_cnt;
    logic [31:0] lfsr_q;
    cipher_req_t fixed_req [2];
    block_t      fixed_ct [2];

    feistel48_top uut (
        .clk     (clk),
        .reset   (reset),
        .start_i (start_i),
        .req_i   (req_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .block_o (block_o)
    );

    always #20 clk = ~clk;

    initial begin
        timeout_cnt = 0;
        while (timeout_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            timeout_cnt++;
        end
        $display("timeout after %0d cycles, simulation stopped", timeout_cnt);
        $display("TEST FAILED");
        $finish;
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic draw_bits(input int n, output logic [255:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[254:0], lfsr_q[0]};
        end
    endtask

    // Called a little after a rising edge; returns in the cycle done_o is high
    task automatic run_op(input cipher_req_t req, input int inject_at,
                          input cipher_req_t other, output block_t result);
        int cycles;
        bit busy_low;
        cycles   = 0;
        busy_low = 0;
        req_i    = req;
        start_i  = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            start_i = 1'b0;
            cycles++;
            if (cycles == inject_at) begin
                req_i   = other;
                start_i = 1'b1;
            end else if (cycles == inject_at + 1) begin
                req_i = req;
            end
            if (!done_o && !busy_o) busy_low = 1;
        end while (!done_o);
        if (cycles != OP_CYCLES) begin
            $display("done_o arrived %0d cycles after start instead of %0d", cycles, OP_CYCLES);
            error_count++;
        end
        if (busy_low) begin
            $display("busy_o dropped before done_o");
            error_count++;
        end
        check_value("busy_o", 128'h0, busy_o);
        result = block_o;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == test_errs) begin
            $display("%-28s ok", name);
        end else begin
            tests_failed++;
            $display("%-28s %0d errors", name, error_count - test_errs);
        end
        test_errs = error_count;
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset_state();
        check_value("busy_o", 128'h0, busy_o);
        check_value("done_o", 128'h0, done_o);
        check_value("block_o", 128'h0, block_o);
        finish_test("reset state");
    endtask

    task automatic test_encrypt_fixed();
        block_t result;
        fixed_req[0].key   = '0;
        fixed_req[0].block = '0;
        fixed_req[0].dir   = CIPHER_ENCRYPT;
        fixed_req[1].key   = 256'h000102030405060708090a0b0c0d0e0f_f0e1d2c3b4a5968778695a4b3c2d1e0f;
        fixed_req[1].block = 128'h0123456789abcdef_fedcba9876543210;
        fixed_req[1].dir   = CIPHER_ENCRYPT;
        for (int i = 0; i < 2; i++) begin
            run_op(fixed_req[i], 0, fixed_req[i], result);
            check_value("block_o", model_cipher(fixed_req[i]), result);
            fixed_ct[i] = result;
        end
        finish_test("encrypt fixed");
    endtask

    task automatic test_decrypt();
        cipher_req_t req;
        block_t      result;
        for (int i = 0; i < 2; i++) begin
            req       = fixed_req[i];
            req.block = fixed_ct[i];
            req.dir   = CIPHER_DECRYPT;
            run_op(req, 0, req, result);
            check_value("block_o", fixed_req[i].block, result);
        end
        req.key   = 256'h3141592653589793238462643383279502884197169399375105820974944592;
        req.block = 128'h6a09e667f3bcc908_bb67ae8584caa73b;
        req.dir   = CIPHER_DECRYPT;
        run_op(req, 0, req, result);
        check_value("block_o", model_cipher(req), result);
        finish_test("decrypt");
    endtask

    task automatic test_ignored_start();
        cipher_req_t other;
        block_t      result;
        int          extra;
        extra       = 0;
        other.key   = ~fixed_req[1].key;
        other.block = ~fixed_req[1].block;
        other.dir   = CIPHER_DECRYPT;
        // Second start lands while keys are still being written
        run_op(fixed_req[1], 30, other, result);
        check_value("block_o", model_cipher(fixed_req[1]), result);
        repeat (OP_CYCLES + 1) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (done_o || busy_o) extra++;
        end
        if (extra != 0) begin
            $display("ignored start still launched an operation");
            error_count++;
        end
        finish_test("start while busy");
    endtask

    // Ten random sets, each followed by its inverse, twenty operations
    task automatic test_back_to_back();
        cipher_req_t  fwd;
        cipher_req_t  inv;
        block_t       result;
        logic [255:0] bits;
        for (int p = 0; p < 10; p++) begin
            draw_bits(256, bits);
            fwd.key = bits;
            draw_bits(128, bits);
            fwd.block = bits[127:0];
            draw_bits(1, bits);
            fwd.dir = cipher_dir_e'(bits[0]);
            run_op(fwd, 0, fwd, result);
            check_value("block_o", model_cipher(fwd), result);
            inv.key   = fwd.key;
            inv.block = result;
            inv.dir   = (fwd.dir == CIPHER_ENCRYPT) ? CIPHER_DECRYPT : CIPHER_ENCRYPT;
            run_op(inv, 0, inv, result);
            check_value("block_o", fwd.block, result);
        end
        finish_test("back-to-back round trips");
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        start_i      = 1'b0;
        req_i        = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;
        lfsr_q       = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        test_reset_state();
        test_encrypt_fixed();
        test_decrypt();
        test_ignored_start();
        test_back_to_back();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src/feistel48_top.sv
// Feistel-48 block cipher top level
// 256-bit key, 128-bit block, 48 rounds. A start pulse launches key
// expansion and the rounds. done_o pulses 99 cycles after start and
// block_o holds the result until the next operation finishes
module feistel48_top
    import feistel48_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start_i,
    input  cipher_req_t req_i,
    output logic        busy_o,
    output logic        done_o,
    output block_t      block_o
);

    logic         keys_start;
    logic         keys_done;
    logic         load;
    logic         round_en;
    logic         finish;
    round_idx_t   round_idx;
    cipher_dir_e  dir;
    round_key_t   round_key;
    whiten_keys_t whitening;

    feistel_key_schedule u_key_schedule (
        .clk          (clk),
        .reset        (reset),
        .keys_start_i (keys_start),
        .master_key_i (req_i.key),
        .round_idx_i  (round_idx),
        .keys_done_o  (keys_done),
        .round_key_o  (round_key),
        .whitening_o  (whitening)
    );

    feistel_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start_i),
        .dir_i        (req_i.dir),
        .keys_done_i  (keys_done),
        .keys_start_o (keys_start),
        .load_o       (load),
        .round_en_o   (round_en),
        .finish_o     (finish),
        .round_idx_o  (round_idx),
        .dir_o        (dir),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // Block is read from the request at load time
    feistel_datapath u_datapath (
        .clk         (clk),
        .reset       (reset),
        .load_i      (load),
        .round_en_i  (round_en),
        .finish_i    (finish),
        .dir_i       (dir),
        .block_i     (req_i.block),
        .round_key_i (round_key),
        .whitening_i (whitening),
        .block_o     (block_o)
    );

endmodule

// File: src/feistel_datapath.sv
// Feistel-48 datapath
// Holds the left and right halves, applies the start whitening key on load,
// runs one Feistel round per enabled cycle and on finish swaps the halves,
// applies the end whitening key and updates the output block register
module feistel_datapath
    import feistel48_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         load_i,
    input  logic         round_en_i,
    input  logic         finish_i,
    input  cipher_dir_e  dir_i,
    input  block_t       block_i,
    input  round_key_t   round_key_i,
    input  whiten_keys_t whitening_i,
    output block_t       block_o
);

    half_t      left_q;
    half_t      right_q;
    half_t      f_out;
    round_key_t start_key;
    round_key_t end_key;
    block_t     in_white;
    block_t     out_next;

    feistel_round_function u_round_fn (
        .half_i      (right_q),
        .round_key_i (round_key_i),
        .f_o         (f_out)
    );

    // Whitening keys swap roles for decryption
    assign start_key = (dir_i == CIPHER_ENCRYPT) ? whitening_i.pre  : whitening_i.post;
    assign end_key   = (dir_i == CIPHER_ENCRYPT) ? whitening_i.post : whitening_i.pre;

    assign in_white = block_i ^ start_key;
    assign out_next = {right_q, left_q} ^ end_key;

    // ==============================
    // Feistel state
    // ==============================
    always_ff @(posedge clk) begin
        if (load_i) begin
            // Upper half goes left
            left_q  <= in_white[BLOCK_W-1:HALF_W];
            right_q <= in_white[HALF_W-1:0];
        end else if (round_en_i) begin
            left_q  <= right_q;
            right_q <= left_q ^ f_out;
        end
    end

    // ==============================
    // Output block
    // ==============================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            block_o <= '0;
        end else if (finish_i) begin
            block_o <= out_next;
        end
    end

    // Operation steps are mutually exclusive
    a_one_step: assert property (@(posedge clk) disable iff (reset)
        $onehot0({load_i, round_en_i, finish_i}));

endmodule

// File: src/feistel_ctrl.sv
// Feistel-48 controller
// Sequences key expansion, load, 48 rounds and finish. Latches the
// direction at start and presents the round index ascending for
// encryption, descending for decryption
module feistel_ctrl
    import feistel48_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start_i,
    input  cipher_dir_e dir_i,
    input  logic        keys_done_i,
    output logic        keys_start_o,
    output logic        load_o,
    output logic        round_en_o,
    output logic        finish_o,
    output round_idx_t  round_idx_o,
    output cipher_dir_e dir_o,
    output logic        busy_o,
    output logic        done_o
);

    ctrl_state_e state_q;
    round_idx_t  round_cnt_q;
    cipher_dir_e dir_q;
    logic        last_round;

    assign last_round = round_cnt_q == ROUND_IDX_W'(ROUNDS - 1);

    // Start is only honoured when idle
    assign keys_start_o = start_i && (state_q == ST_IDLE);
    assign load_o       = (state_q == ST_KEYS) && keys_done_i;
    assign round_en_o   = state_q == ST_ROUNDS;
    assign finish_o     = state_q == ST_DONE;
    assign busy_o       = state_q != ST_IDLE;
    assign dir_o        = dir_q;

    // Decryption walks the key file backwards
    assign round_idx_o = (dir_q == CIPHER_DECRYPT) ?
                         ROUND_IDX_W'(ROUNDS - 1) - round_cnt_q : round_cnt_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= ST_IDLE;
            round_cnt_q <= '0;
            dir_q       <= CIPHER_ENCRYPT;
            done_o      <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (keys_start_o) begin
                        state_q <= ST_KEYS;
                        dir_q   <= dir_i;
                    end
                end
                ST_KEYS: begin
                    if (keys_done_i) begin
                        state_q     <= ST_ROUNDS;
                        round_cnt_q <= '0;
                    end
                end
                ST_ROUNDS: begin
                    if (last_round) begin
                        state_q <= ST_DONE;
                    end else begin
                        round_cnt_q <= round_cnt_q + 1'b1;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                    done_o  <= 1'b1;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done_o |=> !done_o);

    // Rounds only run after a load, back to back
    a_round_after_load: assert property (@(posedge clk) disable iff (reset)
        round_en_o |-> $past(load_o) || $past(round_en_o));

endmodule

// File: src/feistel_key_schedule.sv
// Feistel-48 key schedule
// Captures the master key on keys_start_i, then writes one round key per
// cycle into a 48-entry register file. Whitening keys are registered at
// capture. Round keys are read combinationally by round index
module feistel_key_schedule
    import feistel48_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         keys_start_i,
    input  master_key_t  master_key_i,
    input  round_idx_t   round_idx_i,
    output logic         keys_done_o,
    output round_key_t   round_key_o,
    output whiten_keys_t whitening_o
);

    round_key_t  rk_mem [ROUNDS];
    master_key_t prk_next;
    master_key_t prk_q;
    master_key_t phi_acc_q;
    master_key_t mix_in;
    master_key_t mix_sum;
    round_idx_t  wr_cnt_q;
    logic        running_q;

    assign prk_next = master_key_i ^ HKDF_SALT;

    // PRK xor r*PHI, rotated left by one word and added to itself
    assign mix_in  = prk_q ^ phi_acc_q;
    assign mix_sum = {mix_in[KEY_W-33:0], mix_in[KEY_W-1:KEY_W-32]} + mix_in;

    assign round_key_o = rk_mem[round_idx_i];

    // ==============================
    // Write sequencing
    // ==============================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running_q   <= 1'b0;
            wr_cnt_q    <= '0;
            keys_done_o <= 1'b0;
        end else begin
            keys_done_o <= 1'b0;
            if (keys_start_i) begin
                running_q <= 1'b1;
                wr_cnt_q  <= '0;
            end else if (running_q) begin
                if (wr_cnt_q == ROUND_IDX_W'(ROUNDS - 1)) begin
                    running_q   <= 1'b0;
                    wr_cnt_q    <= '0;
                    keys_done_o <= 1'b1;
                end else begin
                    wr_cnt_q <= wr_cnt_q + 1'b1;
                end
            end
        end
    end

    // Key material
    always_ff @(posedge clk) begin
        if (keys_start_i) begin
            prk_q            <= prk_next;
            phi_acc_q        <= '0;
            whitening_o.pre  <= prk_next[ROUND_KEY_W-1:0] ^ PRE_WHITEN_CONST[ROUND_KEY_W-1:0];
            whitening_o.post <= prk_next[KEY_W-1:ROUND_KEY_W]
                              ^ POST_WHITEN_CONST[KEY_W-1:ROUND_KEY_W];
        end else if (running_q) begin
            rk_mem[wr_cnt_q] <= mix_sum[ROUND_KEY_W-1:0] ^ mix_sum[KEY_W-1:ROUND_KEY_W];
            phi_acc_q        <= phi_acc_q + PHI_256;
        end
    end

    // Controller must not restart the schedule mid-expansion
    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        keys_start_i |-> !running_q);

endmodule

// File: src/feistel_round_function.sv
// Feistel-48 round F-function
// Combinational: key XOR, AES byte substitution, rotate-XOR diffusion,
// add-rotate-XOR with the golden constant and a final key XOR
module feistel_round_function
    import feistel48_pkg::*;
(
    input  half_t      half_i,
    input  round_key_t round_key_i,
    output half_t      f_o
);

    half_t key_mix;
    half_t sub;
    half_t diff;
    half_t arx;

    always_comb begin
        // Lower key half goes in first
        key_mix = half_i ^ round_key_i[HALF_W-1:0];

        // Byte-wise S-box
        for (int b = 0; b < HALF_W / 8; b++) begin
            sub[b*8 +: 8] = SBOX[key_mix[b*8 +: 8]];
        end

        // Diffusion, rotate right by 7 and by 11
        diff = sub
             ^ {sub[6:0], sub[HALF_W-1:7]}
             ^ {sub[10:0], sub[HALF_W-1:11]};

        // ARX stage, rotate left by 13 and right by 29
        arx = (diff + PHI_64)
            ^ {diff[HALF_W-14:0], diff[HALF_W-1:HALF_W-13]}
            ^ {diff[28:0], diff[HALF_W-1:29]};

        f_o = arx ^ round_key_i[ROUND_KEY_W-1:HALF_W];
    end

endmodule

// File: src/feistel48_pkg.sv
// Feistel-48 shared definitions
// Widths, golden-ratio constants, key schedule constants, the AES S-box,
// and the request, whitening key, direction and FSM state types
package feistel48_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int BLOCK_W     = 128;
    localparam int HALF_W      = 64;
    localparam int KEY_W       = 256;
    localparam int ROUND_KEY_W = 128;
    localparam int ROUNDS      = 48;
    localparam int ROUND_IDX_W = 6;

    // ==============================
    // Constants
    // ==============================
    localparam logic [HALF_W-1:0] PHI_64  = 64'h9E37_79B9_7F4A_7C15;
    // Step of the key schedule accumulator
    localparam logic [KEY_W-1:0]  PHI_256 = {4{PHI_64}};

    localparam logic [KEY_W-1:0] HKDF_SALT =
        256'h00112233445566778899AABBCCDDEEFF00112233445566778899AABBCCDDEEFF;
    localparam logic [KEY_W-1:0] PRE_WHITEN_CONST =
        256'hA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55A;
    localparam logic [KEY_W-1:0] POST_WHITEN_CONST =
        256'h5AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA55AA5;

    // AES forward S-box
    localparam logic [7:0] SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // ==============================
    // Types
    // ==============================
    typedef logic [HALF_W-1:0]      half_t;
    typedef logic [BLOCK_W-1:0]     block_t;
    typedef logic [KEY_W-1:0]       master_key_t;
    typedef logic [ROUND_KEY_W-1:0] round_key_t;
    typedef logic [ROUND_IDX_W-1:0] round_idx_t;

    typedef enum logic [0:0] {
        CIPHER_ENCRYPT = 1'b0,
        CIPHER_DECRYPT = 1'b1
    } cipher_dir_e;

    typedef struct packed {
        master_key_t key;
        block_t      block;
        cipher_dir_e dir;
    } cipher_req_t;

    typedef struct packed {
        round_key_t pre;
        round_key_t post;
    } whiten_keys_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_KEYS   = 2'd1,
        ST_ROUNDS = 2'd2,
        ST_DONE   = 2'd3
    } ctrl_state_e;

endpackage
